//--- sources.f
sv32_pkg.sv
priv_pkg.sv
sv32_tlb.sv
sv32_walker.sv
mem_arbiter.sv
sv32_access.sv
sv32_mmu.sv
tb_mem_model.sv
tb_sv32_mmu.sv

//--- Bender.yml
package:
  name: sv32_mmu

sources:
  - sv32_pkg.sv
  - priv_pkg.sv
  - sv32_tlb.sv
  - sv32_walker.sv
  - mem_arbiter.sv
  - sv32_access.sv
  - sv32_mmu.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_sv32_mmu.sv

//--- tb_sv32_mmu.sv
// Testbench for the Sv32 MMU with page-table setup, reference translation and response checks
`timescale 1ns/100ps

module tb_sv32_mmu
  import sv32_pkg::*;
;

  localparam int NUM_REQUESTS = 12;
  localparam logic [31:0] SATP_ON = 32'h8000_0100;  // Sv32, root table at ppn 0x100
  localparam logic [7:0] F_V = 8'h01;
  localparam logic [7:0] F_R = 8'h02;
  localparam logic [7:0] F_W = 8'h04;
  localparam logic [7:0] F_X = 8'h08;
  localparam logic [7:0] F_A = 8'h40;
  localparam logic [7:0] F_D = 8'h80;

  logic        clk;
  logic        reset;
  logic        cpu_valid;
  logic [31:0] cpu_addr;
  logic [3:0]  cpu_wstrb;
  logic [31:0] cpu_wdata;
  logic        is_instruction;
  logic        cpu_ready;
  logic [31:0] cpu_rdata;
  logic        page_fault;
  logic [31:0] fault_address;
  logic        tlb_flush;
  logic [31:0] satp;
  logic [1:0]  privilege_mode;
  logic        mem_valid;
  logic        mem_ready;
  logic [33:0] mem_addr;
  logic [3:0]  mem_wstrb;
  logic [31:0] mem_wdata;
  logic [31:0] mem_rdata;
  logic [31:0] beat_count;

  logic [31:0] ref_mem [logic [31:0]];  // Testbench copy of memory
  logic        exp_fault;
  logic        exp_read;
  logic [31:0] exp_rdata;
  logic [31:0] exp_va;
  logic [33:0] last_beat_addr;
  int          errors;
  int          responses;

  sv32_mmu #(.NUM_TLB_ENTRIES(16)) sv32_mmu_inst (
    .clk(clk), .reset(reset),
    .cpu_valid(cpu_valid), .cpu_addr(cpu_addr), .cpu_wstrb(cpu_wstrb),
    .cpu_wdata(cpu_wdata), .is_instruction(is_instruction), .cpu_ready(cpu_ready),
    .cpu_rdata(cpu_rdata), .page_fault(page_fault), .fault_address(fault_address),
    .tlb_flush(tlb_flush), .satp(satp), .privilege_mode(privilege_mode),
    .mem_valid(mem_valid), .mem_ready(mem_ready), .mem_addr(mem_addr),
    .mem_wstrb(mem_wstrb), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
  );

  tb_mem_model tb_mem_model_inst (
    .clk(clk), .reset(reset), .mem_valid(mem_valid), .mem_ready(mem_ready),
    .mem_addr(mem_addr), .mem_wstrb(mem_wstrb), .mem_wdata(mem_wdata),
    .mem_rdata(mem_rdata), .beat_count(beat_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #((NUM_REQUESTS * 200 + 20) * 8);
    $display("Watchdog timeout: the MMU stopped answering requests");
    $display("Test failures found");
    $finish;
  end

  function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [7:0] flags);
    return {ppn, 2'b00, flags};
  endfunction

  function automatic logic [31:0] ref_read(input logic [33:0] pa);
    return ref_mem.exists(pa[33:2]) ? ref_mem[pa[33:2]] : 32'h0;
  endfunction

  // Word in both the memory model and the testbench copy
  task automatic set_word(input logic [33:0] pa, input logic [31:0] d);
    ref_mem[pa[33:2]] = d;
    tb_mem_model_inst.store_word(pa[33:2], d);
  endtask

  // Sv32 translation by the walk rules, counting PTE reads
  function automatic logic ref_translate(input logic [31:0] va, input logic store,
                                         input logic fetch, input logic [1:0] priv,
                                         input logic [31:0] satp_v, output logic [33:0] pa,
                                         output int reads);
    pte_t        pte;
    logic [33:0] a;
    logic        perm;
    int          level;
    reads = 0;
    pa    = {2'b00, va};
    if (!satp_v[31] || priv == 2'd3) return 1'b0;
    a = {satp_v[21:0], va[31:22], 2'b00};
    for (level = 1; level >= 0; level--) begin
      pte = pte_t'(ref_read(a));
      reads++;
      if (!pte.v || (pte.w && !pte.r)) return 1'b1;
      if (pte.r || pte.x) begin
        if (level == 1 && pte.ppn0 != 10'd0) return 1'b1;
        perm = fetch ? pte.x : (store ? pte.w : pte.r);
        if (!perm) return 1'b1;
        if ((priv == 2'd0) != pte.u) return 1'b1;
        if (!pte.a || (store && !pte.d)) return 1'b1;
        if (level == 1) pa = {pte.ppn1, va[21:0]};
        else pa = {pte.ppn1, pte.ppn0, va[11:0]};
        return 1'b0;
      end
      a = {pte.ppn1, pte.ppn0, va[21:12], 2'b00};
    end
    return 1'b1;  // Pointer found in the leaf table
  endfunction

  // Address of the most recent completed memory beat
  always @(posedge clk) begin
    if (mem_valid && mem_ready) last_beat_addr <= mem_addr;
  end

  // Response checker
  always @(posedge clk) begin
    if (!reset && cpu_ready) begin
      responses++;
      if (page_fault !== exp_fault) begin
        $display("Mismatch at %0t: page_fault expected %b got %b", $time, exp_fault,
                 page_fault);
        errors++;
      end
      if (exp_fault && fault_address !== exp_va) begin
        $display("Mismatch at %0t: fault_address expected %h got %h", $time, exp_va,
                 fault_address);
        errors++;
      end
      if (!exp_fault && exp_read && cpu_rdata !== exp_rdata) begin
        $display("Mismatch at %0t: cpu_rdata expected %h got %h", $time, exp_rdata,
                 cpu_rdata);
        errors++;
      end
    end
  end

  task automatic do_request(input logic [31:0] va, input logic [3:0] wstrb,
                            input logic [31:0] wdata, input logic fetch,
                            input logic [1:0] priv, input logic [31:0] satp_v,
                            input logic exp_hit);
    logic [33:0] pa;
    logic [31:0] word;
    logic [31:0] start_beats;
    int          reads;
    int          exp_beats;
    int          b;
    @(posedge clk);
    exp_fault = ref_translate(va, |wstrb, fetch, priv, satp_v, pa, reads);
    exp_read  = (wstrb == 4'b0000);
    exp_rdata = ref_read(pa);
    exp_va    = va;
    exp_beats = exp_hit ? 0 : reads;
    if (!exp_fault) exp_beats++;
    start_beats = beat_count;
    satp           <= satp_v;
    privilege_mode <= priv;
    is_instruction <= fetch;
    cpu_addr       <= va;
    cpu_wstrb      <= wstrb;
    cpu_wdata      <= wdata;
    cpu_valid      <= 1'b1;
    do @(posedge clk); while (!cpu_ready);
    cpu_valid <= 1'b0;
    if (beat_count - start_beats != exp_beats) begin
      $display("Mismatch at %0t: beat_count delta expected %0d got %0d", $time, exp_beats,
               beat_count - start_beats);
      errors++;
    end
    if (!exp_fault && last_beat_addr !== pa) begin
      $display("Mismatch at %0t: mem_addr expected %h got %h", $time, pa, last_beat_addr);
      errors++;
    end
    if (!exp_fault && !exp_read) begin
      word = ref_read(pa);
      for (b = 0; b < 4; b++) begin
        if (wstrb[b]) word[b*8 +: 8] = wdata[b*8 +: 8];
      end
      ref_mem[pa[33:2]] = word;
    end
  endtask

  task automatic flush_tlb();
    @(posedge clk);
    tlb_flush <= 1'b1;
    @(posedge clk);
    tlb_flush <= 1'b0;
  endtask

  initial begin
    errors         = 0;
    responses      = 0;
    reset          = 1'b1;
    cpu_valid      = 1'b0;
    cpu_addr       = '0;
    cpu_wstrb      = '0;
    cpu_wdata      = '0;
    is_instruction = 1'b0;
    tlb_flush      = 1'b0;
    satp           = '0;
    privilege_mode = 2'd3;
    // Root table at 0x100000, leaf table at 0x101000
    set_word(34'h0010_0004, make_pte(22'h00101, F_V));                   // vpn1 1
    set_word(34'h0010_0008, make_pte(22'h00C00, F_V | F_R | F_W | F_X | F_A | F_D));
    set_word(34'h0010_1000, make_pte(22'h00200, F_V | F_R | F_W | F_X | F_A | F_D));
    set_word(34'h0010_1004, make_pte(22'h00201, F_V | F_R | F_A));      // No w
    set_word(34'h0010_100C, make_pte(22'h00203, F_V | F_R | F_W | F_A | F_D));  // No x
    set_word(34'h0010_1010, make_pte(22'h00204, F_V | F_R | F_W | F_D)); // a clear
    set_word(34'h0010_1014, make_pte(22'h00205, F_R | F_W));            // v clear
    set_word(34'h0000_1000, 32'h1234_5678);
    set_word(34'h0000_2000, 32'h8765_4321);
    set_word(34'h0020_0020, 32'h5EED_0020);
    set_word(34'h00C0_1234, 32'h0D15_EA5E);  // Megapage target
    set_word(34'h0021_0010, 32'h0BAD_F00D);
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    do_request(32'h0000_1000, 4'h0, '0, 1'b0, 2'd1, 32'h0, 1'b0);     // Bare, mode off
    do_request(32'h0000_2000, 4'h0, '0, 1'b0, 2'd3, SATP_ON, 1'b0);   // Bare, M mode
    do_request(32'h0040_0010, 4'hF, 32'hCAFE_BABE, 1'b0, 2'd1, SATP_ON, 1'b0);
    do_request(32'h0040_0010, 4'h0, '0, 1'b0, 2'd1, SATP_ON, 1'b1);   // Load back, hit
    do_request(32'h0040_0020, 4'h0, '0, 1'b0, 2'd1, SATP_ON, 1'b1);
    do_request(32'h0080_1234, 4'h0, '0, 1'b0, 2'd1, SATP_ON, 1'b0);   // Megapage
    do_request(32'h0040_5000, 4'h0, '0, 1'b0, 2'd1, SATP_ON, 1'b0);   // Invalid PTE
    do_request(32'h0040_1008, 4'hF, 32'h1, 1'b0, 2'd1, SATP_ON, 1'b0);  // Store, no w
    do_request(32'h0040_0030, 4'h0, '0, 1'b0, 2'd0, SATP_ON, 1'b1);   // User, no u
    do_request(32'h0040_3000, 4'h0, '0, 1'b1, 2'd1, SATP_ON, 1'b0);   // Fetch, no x
    do_request(32'h0040_4000, 4'h0, '0, 1'b0, 2'd1, SATP_ON, 1'b0);   // a clear
    set_word(34'h0010_1000, make_pte(22'h00210, F_V | F_R | F_W | F_X | F_A | F_D));
    flush_tlb();
    do_request(32'h0040_0010, 4'h0, '0, 1'b0, 2'd1, SATP_ON, 1'b0);   // Walks again

    repeat (2) @(posedge clk);
    if (responses != NUM_REQUESTS) begin
      $display("Wrong number of responses: expected %0d, saw %0d", NUM_REQUESTS, responses);
      errors++;
    end
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- tb_mem_model.sv
// Testbench word memory with random ready latency, byte-strobed writes and a beat counter
`timescale 1ns/100ps

module tb_mem_model (
  input  logic        clk,
  input  logic        reset,
  input  logic        mem_valid,
  output logic        mem_ready,
  input  logic [33:0] mem_addr,
  input  logic [3:0]  mem_wstrb,
  input  logic [31:0] mem_wdata,
  output logic [31:0] mem_rdata,
  output logic [31:0] beat_count
);

  logic [31:0] mem [logic [31:0]];  // Sparse, keyed by word index
  integer      seed;
  integer      wait_left;
  logic        busy;
  logic [31:0] widx;
  logic [31:0] word;
  int          b;

  initial seed = 15028;

  // Pattern for words never written, spread over the whole word index
  function automatic logic [31:0] fill_word(input logic [31:0] w);
    return {w[15:0], w[31:16]} ^ 32'hC3A5_5A3C;
  endfunction

  task automatic store_word(input logic [31:0] w, input logic [31:0] d);
    mem[w] = d;
  endtask

  always @(posedge clk) begin
    if (reset) begin
      mem_ready  <= 1'b0;
      mem_rdata  <= '0;
      beat_count <= '0;
      busy       <= 1'b0;
      wait_left  = 0;
    end else begin
      mem_ready <= 1'b0;
      if (mem_ready) begin
        busy <= 1'b0;                      // Valid seen here still belongs to the old beat
      end else if (mem_valid) begin
        if (!busy) begin
          busy <= 1'b1;
          wait_left = {$random(seed)} % 4;
        end
        if (wait_left == 0) begin
          widx = mem_addr[33:2];
          word = mem.exists(widx) ? mem[widx] : fill_word(widx);
          for (b = 0; b < 4; b++) begin
            if (mem_wstrb[b]) word[b*8 +: 8] = mem_wdata[b*8 +: 8];
          end
          if (|mem_wstrb) mem[widx] = word;
          mem_rdata  <= word;
          mem_ready  <= 1'b1;
          beat_count <= beat_count + 1;
        end else begin
          wait_left = wait_left - 1;
        end
      end
    end
  end

endmodule

//--- sv32_mmu.sv
// Sv32 MMU top level joining sequencer, TLB, page walker and memory arbiter
`timescale 1ns/100ps

module sv32_mmu
  import sv32_pkg::*;
#(
  parameter int NUM_TLB_ENTRIES = 16
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               cpu_valid,
  input  logic [31:0]        cpu_addr,
  input  logic [3:0]         cpu_wstrb,
  input  logic [31:0]        cpu_wdata,
  input  logic               is_instruction,
  output logic               cpu_ready,
  output logic [31:0]        cpu_rdata,
  output logic               page_fault,
  output logic [31:0]        fault_address,
  input  logic               tlb_flush,
  input  logic [31:0]        satp,
  input  logic [1:0]         privilege_mode,
  output logic               mem_valid,
  input  logic               mem_ready,
  output logic [PADDR_W-1:0] mem_addr,
  output logic [3:0]         mem_wstrb,
  output logic [31:0]        mem_wdata,
  input  logic [31:0]        mem_rdata
);

  logic               tlb_lookup;
  logic [2*VPN_W-1:0] tlb_vpn;
  logic               tlb_hit;
  logic [PPN_W-1:0]   tlb_ppn;
  pte_t               tlb_flags;
  logic               tlb_fill;

  logic               walk_start;
  logic               walk_done;
  logic               walk_fault;
  pte_t               walk_leaf;
  logic               walk_mega;

  logic               wlk_valid;
  logic               wlk_ready;
  logic [PADDR_W-1:0] wlk_addr;
  mem_word_u          wlk_rdata;
  logic               acc_valid;
  logic               acc_ready;
  logic [PADDR_W-1:0] acc_addr;
  logic [3:0]         acc_wstrb;
  logic [31:0]        acc_wdata;
  mem_word_u          acc_rdata;

  sv32_access sv32_access_inst (
    .clk           (clk),
    .reset         (reset),
    .cpu_valid     (cpu_valid),
    .cpu_addr      (cpu_addr),
    .cpu_wstrb     (cpu_wstrb),
    .cpu_wdata     (cpu_wdata),
    .is_instruction(is_instruction),
    .cpu_ready     (cpu_ready),
    .cpu_rdata     (cpu_rdata),
    .page_fault    (page_fault),
    .fault_address (fault_address),
    .satp          (satp),
    .privilege_mode(privilege_mode),
    .tlb_lookup    (tlb_lookup),
    .tlb_vpn       (tlb_vpn),
    .tlb_hit       (tlb_hit),
    .tlb_ppn       (tlb_ppn),
    .tlb_flags     (tlb_flags),
    .tlb_fill      (tlb_fill),
    .walk_start    (walk_start),
    .walk_done     (walk_done),
    .walk_fault    (walk_fault),
    .walk_leaf     (walk_leaf),
    .walk_mega     (walk_mega),
    .acc_valid     (acc_valid),
    .acc_ready     (acc_ready),
    .acc_addr      (acc_addr),
    .acc_wstrb     (acc_wstrb),
    .acc_wdata     (acc_wdata),
    .acc_rdata     (acc_rdata)
  );

  sv32_tlb #(
    .NUM_TLB_ENTRIES(NUM_TLB_ENTRIES)
  ) sv32_tlb_inst (
    .clk       (clk),
    .reset     (reset),
    .flush     (tlb_flush),
    .lookup    (tlb_lookup),
    .vpn       (tlb_vpn),
    .hit       (tlb_hit),
    .ppn       (tlb_ppn),
    .flags     (tlb_flags),
    .fill      (tlb_fill),
    .fill_vpn  (tlb_vpn),
    .fill_ppn  (acc_addr[PADDR_W-1:OFFSET_W]),  // Composed page from the sequencer
    .fill_flags(walk_leaf)
  );

  sv32_walker sv32_walker_inst (
    .clk           (clk),
    .reset         (reset),
    .walk_start    (walk_start),
    .vaddr         (cpu_addr),
    .is_store      (|cpu_wstrb),
    .is_instruction(is_instruction),
    .privilege_mode(privilege_mode),
    .satp          (satp),
    .walk_done     (walk_done),
    .walk_fault    (walk_fault),
    .walk_leaf     (walk_leaf),
    .walk_mega     (walk_mega),
    .wlk_valid     (wlk_valid),
    .wlk_ready     (wlk_ready),
    .wlk_addr      (wlk_addr),
    .wlk_rdata     (wlk_rdata)
  );

  mem_arbiter mem_arbiter_inst (
    .clk      (clk),
    .reset    (reset),
    .wlk_valid(wlk_valid),
    .wlk_ready(wlk_ready),
    .wlk_addr (wlk_addr),
    .wlk_rdata(wlk_rdata),
    .acc_valid(acc_valid),
    .acc_ready(acc_ready),
    .acc_addr (acc_addr),
    .acc_wstrb(acc_wstrb),
    .acc_wdata(acc_wdata),
    .acc_rdata(acc_rdata),
    .mem_valid(mem_valid),
    .mem_ready(mem_ready),
    .mem_addr (mem_addr),
    .mem_wstrb(mem_wstrb),
    .mem_wdata(mem_wdata),
    .mem_rdata(mem_rdata)
  );

endmodule

//--- sv32_access.sv
// Sv32 request sequencer: bare or translated access, TLB and walker control, final data beat
`timescale 1ns/100ps

module sv32_access
  import sv32_pkg::*;
  import priv_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  logic               cpu_valid,
  input  logic [31:0]        cpu_addr,
  input  logic [3:0]         cpu_wstrb,
  input  logic [31:0]        cpu_wdata,
  input  logic               is_instruction,
  output logic               cpu_ready,
  output logic [31:0]        cpu_rdata,
  output logic               page_fault,
  output logic [31:0]        fault_address,
  input  logic [31:0]        satp,
  input  logic [1:0]         privilege_mode,
  output logic               tlb_lookup,
  output logic [2*VPN_W-1:0] tlb_vpn,
  input  logic               tlb_hit,
  input  logic [PPN_W-1:0]   tlb_ppn,
  input  pte_t               tlb_flags,
  output logic               tlb_fill,
  output logic               walk_start,
  input  logic               walk_done,
  input  logic               walk_fault,
  input  pte_t               walk_leaf,
  input  logic               walk_mega,
  output logic               acc_valid,
  input  logic               acc_ready,
  output logic [PADDR_W-1:0] acc_addr,
  output logic [3:0]         acc_wstrb,
  output logic [31:0]        acc_wdata,
  input  mem_word_u          acc_rdata
);

  localparam logic [2:0] S_IDLE    = 3'd0;
  localparam logic [2:0] S_LOOKUP  = 3'd1;
  localparam logic [2:0] S_WALK    = 3'd2;
  localparam logic [2:0] S_ACCESS  = 3'd3;
  localparam logic [2:0] S_RESPOND = 3'd4;

  logic [2:0]         state;
  logic               translate;
  logic               is_store;
  logic               fault_q;
  fault_e             hit_reason;
  logic [PADDR_W-1:0] pa_q;
  logic [31:0]        rdata_q;

  assign translate  = satp[SATP_MODE_BIT] && (privilege_mode != PRIV_M);
  assign is_store   = |cpu_wstrb;
  assign hit_reason = leaf_check(tlb_flags, is_store, is_instruction, privilege_mode);

  assign tlb_lookup = (state == S_IDLE) && cpu_valid && translate;
  assign tlb_vpn    = cpu_addr[31:OFFSET_W];   // Core holds the address until cpu_ready
  assign walk_start = (state == S_LOOKUP) && !tlb_hit;

  assign acc_valid = (state == S_ACCESS);
  assign acc_addr  = pa_q;
  assign acc_wstrb = cpu_wstrb;
  assign acc_wdata = cpu_wdata;

  assign cpu_ready     = (state == S_RESPOND);
  assign page_fault    = cpu_ready && fault_q;
  assign cpu_rdata     = rdata_q;
  assign fault_address = cpu_addr;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= S_IDLE;
      fault_q  <= 1'b0;
      tlb_fill <= 1'b0;
    end else begin
      tlb_fill <= 1'b0;
      case (state)
        S_IDLE: if (cpu_valid) begin
          fault_q <= 1'b0;
          state   <= translate ? S_LOOKUP : S_ACCESS;
        end
        S_LOOKUP: if (!tlb_hit) begin
          state <= S_WALK;
        end else if (hit_reason != FAULT_NONE) begin
          fault_q <= 1'b1;
          state   <= S_RESPOND;
        end else begin
          state <= S_ACCESS;
        end
        S_WALK: if (walk_done) begin
          fault_q  <= walk_fault;
          tlb_fill <= !walk_fault;           // pa_q holds the fill ppn next cycle
          state    <= walk_fault ? S_RESPOND : S_ACCESS;
        end
        S_ACCESS: if (acc_ready) state <= S_RESPOND;
        default: state <= S_IDLE;
      endcase
    end
  end

  // Physical address and read data
  always_ff @(posedge clk) begin
    case (state)
      S_IDLE:   pa_q <= {2'b00, cpu_addr};   // Bare mode
      S_LOOKUP: pa_q <= {tlb_ppn, cpu_addr[OFFSET_W-1:0]};
      S_WALK:   pa_q <= {walk_leaf.ppn1, walk_mega ? cpu_addr[21:12] : walk_leaf.ppn0,
                         cpu_addr[OFFSET_W-1:0]};
      S_ACCESS: if (acc_ready) rdata_q <= acc_rdata.data;
      default: ;
    endcase
  end

  assert property (@(posedge clk) disable iff (reset) cpu_ready |=> !cpu_ready);

endmodule

//--- mem_arbiter.sv
// Fixed-priority memory arbiter with grant lock, walker first, access sequencer second
`timescale 1ns/100ps

module mem_arbiter
  import sv32_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  logic               wlk_valid,
  output logic               wlk_ready,
  input  logic [PADDR_W-1:0] wlk_addr,
  output logic [31:0]        wlk_rdata,
  input  logic               acc_valid,
  output logic               acc_ready,
  input  logic [PADDR_W-1:0] acc_addr,
  input  logic [3:0]         acc_wstrb,
  input  logic [31:0]        acc_wdata,
  output logic [31:0]        acc_rdata,
  output logic               mem_valid,
  input  logic               mem_ready,
  output logic [PADDR_W-1:0] mem_addr,
  output logic [3:0]         mem_wstrb,
  output logic [31:0]        mem_wdata,
  input  logic [31:0]        mem_rdata
);

  logic locked;
  logic lock_wlk;   // Owner while locked
  logic grant_wlk;
  logic grant_acc;

  assign grant_wlk = locked ? lock_wlk : wlk_valid;
  assign grant_acc = locked ? !lock_wlk : (!wlk_valid && acc_valid);

  assign mem_valid = (grant_wlk && wlk_valid) || (grant_acc && acc_valid);
  assign mem_addr  = grant_wlk ? wlk_addr : acc_addr;
  assign mem_wstrb = grant_wlk ? 4'b0000 : acc_wstrb;  // Walker only reads
  assign mem_wdata = acc_wdata;

  assign wlk_ready = grant_wlk && mem_ready;
  assign acc_ready = grant_acc && mem_ready;
  assign wlk_rdata = mem_rdata;
  assign acc_rdata = mem_rdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      locked   <= 1'b0;
      lock_wlk <= 1'b0;
    end else if (mem_ready) begin
      locked <= 1'b0;                      // Beat done, bus free again
    end else if (mem_valid && !locked) begin
      locked   <= 1'b1;
      lock_wlk <= grant_wlk;
    end
  end

  assert property (@(posedge clk) disable iff (reset) !(wlk_valid && acc_valid));

endmodule

//--- sv32_walker.sv
// Sv32 two-level hardware page-table walker with leaf validity and permission checks
`timescale 1ns/100ps

module sv32_walker
  import sv32_pkg::*;
  import priv_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  logic               walk_start,
  input  logic [31:0]        vaddr,
  input  logic               is_store,
  input  logic               is_instruction,
  input  logic [1:0]         privilege_mode,
  input  logic [31:0]        satp,
  output logic               walk_done,
  output logic               walk_fault,
  output pte_t               walk_leaf,
  output logic               walk_mega,
  output logic               wlk_valid,
  input  logic               wlk_ready,
  output logic [PADDR_W-1:0] wlk_addr,
  input  mem_word_u          wlk_rdata
);

  logic   busy;
  logic   [1:0] level;       // 1 for the root table, 0 for the leaf table
  pte_t   pte;
  logic   is_leaf;
  fault_e step_reason;
  logic   finish;
  logic   descend;

  assign pte       = wlk_rdata.pte;
  assign is_leaf   = pte.r || pte.x;
  assign wlk_valid = busy;

  // Outcome of the PTE on the bus this cycle
  always_comb begin
    step_reason = FAULT_NONE;
    if (!pte.v || (pte.w && !pte.r)) begin
      step_reason = FAULT_INVALID;
    end else if (!is_leaf && level == 2'd0) begin
      step_reason = FAULT_INVALID;         // Pointer below the last level
    end else if (is_leaf && level == 2'd1 && pte.ppn0 != '0) begin
      step_reason = FAULT_MISALIGNED;
    end else if (is_leaf) begin
      step_reason = leaf_check(pte, is_store, is_instruction, privilege_mode);
    end
  end

  assign finish  = busy && wlk_ready && (is_leaf || step_reason != FAULT_NONE);
  assign descend = busy && wlk_ready && !finish;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy       <= 1'b0;
      level      <= 2'd1;
      walk_done  <= 1'b0;
      walk_fault <= 1'b0;
      walk_mega  <= 1'b0;
    end else begin
      walk_done <= 1'b0;
      if (!busy && walk_start) begin
        busy  <= 1'b1;
        level <= 2'd1;
      end else if (finish) begin
        busy       <= 1'b0;
        walk_done  <= 1'b1;
        walk_fault <= (step_reason != FAULT_NONE);
        walk_mega  <= (level == 2'd1);     // Leaf found in the root table
      end else if (descend) begin
        level <= 2'd0;
      end
    end
  end

  // PTE address and leaf capture
  always_ff @(posedge clk) begin
    if (!busy && walk_start) begin
      wlk_addr <= {satp[PPN_W-1:0], vaddr[31:22], 2'b00};
    end else if (descend) begin
      wlk_addr <= {pte.ppn1, pte.ppn0, vaddr[21:12], 2'b00};
    end
    if (finish) begin
      walk_leaf <= pte;
    end
  end

  assert property (@(posedge clk) disable iff (reset) descend |-> level == 2'd1);

endmodule

//--- sv32_tlb.sv
// Direct-mapped Sv32 TLB with registered lookup, single-entry fill and full flush
`timescale 1ns/100ps

module sv32_tlb
  import sv32_pkg::*;
#(
  parameter int NUM_TLB_ENTRIES = 16
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 flush,
  input  logic                 lookup,
  input  logic [2*VPN_W-1:0]   vpn,
  output logic                 hit,
  output logic [PPN_W-1:0]     ppn,
  output pte_t                 flags,
  input  logic                 fill,
  input  logic [2*VPN_W-1:0]   fill_vpn,
  input  logic [PPN_W-1:0]     fill_ppn,
  input  pte_t                 fill_flags
);

  localparam int IDX_W = $clog2(NUM_TLB_ENTRIES);
  localparam int TAG_W = 2 * VPN_W - IDX_W;

  logic [NUM_TLB_ENTRIES-1:0] valid;
  logic [TAG_W-1:0]           tag_mem   [NUM_TLB_ENTRIES];
  logic [PPN_W-1:0]           ppn_mem   [NUM_TLB_ENTRIES];
  pte_t                       flags_mem [NUM_TLB_ENTRIES];

  logic [IDX_W-1:0] idx;
  logic [TAG_W-1:0] tag;
  logic [IDX_W-1:0] fill_idx;
  logic [TAG_W-1:0] fill_tag;

  assign idx      = vpn[IDX_W-1:0];          // Low VPN bits pick the set
  assign tag      = vpn[2*VPN_W-1:IDX_W];
  assign fill_idx = fill_vpn[IDX_W-1:0];
  assign fill_tag = fill_vpn[2*VPN_W-1:IDX_W];

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
      hit   <= 1'b0;
    end else begin
      hit <= lookup && valid[idx] && (tag_mem[idx] == tag);  // Result one cycle later
      if (flush) begin
        valid <= '0;                         // Whole TLB in one cycle
      end else if (fill) begin
        valid[fill_idx] <= 1'b1;
      end
    end
  end

  // Entry storage and read port
  always_ff @(posedge clk) begin
    if (fill) begin
      tag_mem[fill_idx]   <= fill_tag;
      ppn_mem[fill_idx]   <= fill_ppn;       // Megapages arrive already composed
      flags_mem[fill_idx] <= fill_flags;
    end
    if (lookup) begin
      ppn   <= ppn_mem[idx];
      flags <= flags_mem[idx];
    end
  end

endmodule

//--- priv_pkg.sv
// Privilege modes, satp layout, page-fault reasons and the shared leaf permission check
package priv_pkg;
  import sv32_pkg::*;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_e;

  localparam int SATP_MODE_BIT = 31;  // 1 selects Sv32

  typedef enum logic [2:0] {
    FAULT_NONE,
    FAULT_INVALID,
    FAULT_PERMISSION,
    FAULT_ACCESS_BIT,
    FAULT_MISALIGNED
  } fault_e;

  // Permission and A/D check of a valid leaf for one access kind
  function automatic fault_e leaf_check(pte_t pte, logic is_store, logic is_fetch,
                                        logic [1:0] priv);
    logic perm_ok;
    logic user_ok;
    perm_ok = is_fetch ? pte.x : (is_store ? pte.w : pte.r);
    user_ok = (priv == PRIV_U) ? pte.u : !pte.u;  // No SUM, so S never touches U pages
    if (!perm_ok || !user_ok) return FAULT_PERMISSION;
    if (!pte.a || (is_store && !pte.d)) return FAULT_ACCESS_BIT;  // No hardware A/D update
    return FAULT_NONE;
  endfunction

endpackage

//--- sv32_pkg.sv
// Sv32 memory formats: page-table entry layout, memory word views and address widths
package sv32_pkg;

  localparam int VPN_W    = 10;  // One level of the virtual page number
  localparam int OFFSET_W = 12;  // 4 KiB page offset
  localparam int PPN_W    = 22;  // Physical page number
  localparam int PADDR_W  = 34;  // Physical address on the memory bus

  // Sv32 PTE, bit 0 is v
  typedef struct packed {
    logic [11:0] ppn1;
    logic [9:0]  ppn0;
    logic [1:0]  rsw;    // Reserved for software
    logic        d;
    logic        a;
    logic        g;
    logic        u;
    logic        x;
    logic        w;
    logic        r;
    logic        v;
  } pte_t;

  // A memory word seen either as a PTE or as plain data
  typedef union packed {
    pte_t        pte;
    logic [31:0] data;
  } mem_word_u;

endpackage
